// File: mipsMulti.f
+incdir+src
src/mipsPkg.sv
src/registerFile.sv
src/aluUnit.sv
src/mainControl.sv
src/datapath.sv
src/mipsCore.sv
bench/tbClock.sv
bench/mipsCore_asserts.sv
bench/tbTop.sv

// File: run.sh
#!/bin/sh
# Compile the core and testbench with Verilator, then run the simulation.
# The exit status of the simulation is the result of the run.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbTop -f mipsMulti.f -o tbTop
./obj_dir/tbTop

// File: bench/tbTop.sv
`timescale 1ns/10ps
`include "mips_defs.svh"

module tbTop;

   localparam int MemWords    = 512;                        // 2 KB of memory
   localparam int ProgLen     = 42;                         // Program table size
   localparam int NumStores   = 13;
   localparam int ClockPeriod = 40;
   localparam int TimeoutNs   = ProgLen * 5 * ClockPeriod * 2;

   // One expected store
   typedef struct packed {
      mipsPkg::word_t addr;
      mipsPkg::word_t data;
      mipsPkg::word_t pc;    // Store instruction address + 4
   } storeEntry_t;

   logic             iCLK;
   logic             iRST;
   mipsPkg::memReq_t memReq;
   mipsPkg::word_t   memReadData = '0;
   mipsPkg::word_t   pc;

   mipsPkg::word_t   mem [MemWords];
   mipsPkg::word_t   progTable [ProgLen];
   storeEntry_t      expStores [NumStores];
   int               storeIdx = 0;

   // Bus values captured on the falling edge
   logic             pendingWrite = 1'b0;
   mipsPkg::word_t   pendingAddr;
   mipsPkg::word_t   pendingData;
   logic             sampledRead = 1'b0;
   mipsPkg::word_t   sampledAddr = '0;
   logic             firstReadChecked = 1'b0;

   logic [31:0]      rnd;
   logic [15:0]      c1, c2, c3, c4;  // Random immediates
   mipsPkg::word_t   r1, r2;          // Values of $1 and $2

   tbClock #(.Period(ClockPeriod), .ResetCycles(2)) u_tbClock (
      .iCLK (iCLK),
      .iRST (iRST)
   );

   mipsCore u_mipsCore (
      .iCLK        (iCLK),
      .iRST        (iRST),
      .memReq      (memReq),
      .memReadData (memReadData),
      .pc          (pc)
   );

   function automatic mipsPkg::word_t encodeRType(input mipsPkg::regAddr_t rs,
                                                  input mipsPkg::regAddr_t rt,
                                                  input mipsPkg::regAddr_t rd,
                                                  input mipsPkg::funct_t fn);
      return {`MIPS_OP_RTYPE, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic mipsPkg::word_t encodeIType(input mipsPkg::opcode_t op,
                                                  input mipsPkg::regAddr_t rs,
                                                  input mipsPkg::regAddr_t rt,
                                                  input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // Target given as a byte address
   function automatic mipsPkg::word_t encodeJType(input mipsPkg::opcode_t op,
                                                  input mipsPkg::word_t target);
      return {op, target[27:2]};
   endfunction

   task automatic abortRun(input string why);
      $display("%s", why);
      $display("Testbench failed");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   task automatic checkValue(input string name, input mipsPkg::word_t actual,
                             input mipsPkg::word_t expected);
      if (actual !== expected)
         abortRun($sformatf("Fail %s: got 0x%08h, expected 0x%08h", name, actual, expected));
   endtask

   // Next entry of the store table against the bus
   task automatic checkStore(input mipsPkg::word_t addr, input mipsPkg::word_t data,
                             input mipsPkg::word_t pcNow);
      checkValue("memReq.addr", addr, expStores[storeIdx].addr);
      checkValue("memReq.writeData", data, expStores[storeIdx].data);
      checkValue("pc", pcNow, expStores[storeIdx].pc);
      storeIdx++;
      if (storeIdx == NumStores)
      begin
         $display("Testbench passed");
         $finish;
      end
   endtask

   task automatic buildProgram();
      for (int i = 0; i < ProgLen; i++)
         progTable[i] = '0;  // Unused slots decode as add $0
      progTable[0]  = encodeIType(`MIPS_OP_ADDI, 5'd0, 5'd1, c1);
      progTable[1]  = encodeIType(`MIPS_OP_ADDI, 5'd0, 5'd2, c2);
      progTable[2]  = encodeIType(`MIPS_OP_ADDI, 5'd0, 5'd12, 16'h00A1);  // Path markers
      progTable[3]  = encodeIType(`MIPS_OP_ADDI, 5'd0, 5'd13, 16'h00B2);
      progTable[4]  = encodeIType(`MIPS_OP_ADDI, 5'd0, 5'd14, 16'h0BAD);  // Must never be stored
      progTable[5]  = encodeRType(5'd1, 5'd2, 5'd3, `MIPS_FN_ADD);
      progTable[6]  = encodeIType(`MIPS_OP_SW, 5'd0, 5'd3, 16'h0400);
      progTable[7]  = encodeRType(5'd1, 5'd2, 5'd4, `MIPS_FN_SUB);
      progTable[8]  = encodeIType(`MIPS_OP_SW, 5'd0, 5'd4, 16'h0404);
      progTable[9]  = encodeRType(5'd1, 5'd2, 5'd5, `MIPS_FN_AND);
      progTable[10] = encodeIType(`MIPS_OP_SW, 5'd0, 5'd5, 16'h0408);
      progTable[11] = encodeRType(5'd1, 5'd2, 5'd6, `MIPS_FN_OR);
      progTable[12] = encodeIType(`MIPS_OP_SW, 5'd0, 5'd6, 16'h040C);
      progTable[13] = encodeRType(5'd1, 5'd2, 5'd7, `MIPS_FN_SLT);
      progTable[14] = encodeIType(`MIPS_OP_SW, 5'd0, 5'd7, 16'h0410);
      progTable[15] = encodeRType(5'd2, 5'd1, 5'd8, `MIPS_FN_SLT);
      progTable[16] = encodeIType(`MIPS_OP_SW, 5'd0, 5'd8, 16'h0414);
      progTable[17] = encodeIType(`MIPS_OP_ORI, 5'd1, 5'd9, c3);
      progTable[18] = encodeIType(`MIPS_OP_SW, 5'd0, 5'd9, 16'h0418);
      progTable[19] = encodeIType(`MIPS_OP_ANDI, 5'd1, 5'd10, c4);
      progTable[20] = encodeIType(`MIPS_OP_SW, 5'd0, 5'd10, 16'h041C);
      progTable[21] = encodeIType(`MIPS_OP_LW, 5'd0, 5'd11, 16'h0400);   // Reload first store
      progTable[22] = encodeIType(`MIPS_OP_SW, 5'd0, 5'd11, 16'h0420);
      progTable[23] = encodeIType(`MIPS_OP_BEQ, 5'd1, 5'd1, 16'd1);      // Taken
      progTable[24] = encodeIType(`MIPS_OP_SW, 5'd0, 5'd14, 16'h04F0);
      progTable[25] = encodeIType(`MIPS_OP_BEQ, 5'd1, 5'd2, 16'd1);      // Not taken
      progTable[26] = encodeIType(`MIPS_OP_SW, 5'd0, 5'd12, 16'h0424);
      progTable[27] = encodeIType(`MIPS_OP_BNE, 5'd1, 5'd2, 16'd1);      // Taken
      progTable[28] = encodeIType(`MIPS_OP_SW, 5'd0, 5'd14, 16'h04F4);
      progTable[29] = encodeIType(`MIPS_OP_BNE, 5'd1, 5'd1, 16'd1);      // Not taken
      progTable[30] = encodeIType(`MIPS_OP_SW, 5'd0, 5'd13, 16'h0428);
      progTable[31] = encodeJType(`MIPS_OP_JAL, 32'h0000_00A0);          // Call word 40
      progTable[32] = encodeJType(`MIPS_OP_J, 32'h0000_0088);            // Over word 33
      progTable[33] = encodeIType(`MIPS_OP_SW, 5'd0, 5'd14, 16'h04F8);
      progTable[34] = encodeIType(`MIPS_OP_ADDI, 5'd0, 5'd0, c1);        // Write to $zero
      progTable[35] = encodeIType(`MIPS_OP_SW, 5'd0, 5'd0, 16'h0430);
      progTable[36] = encodeJType(`MIPS_OP_J, 32'h0000_0090);            // Park here
      progTable[40] = encodeIType(`MIPS_OP_SW, 5'd0, 5'd31, 16'h042C);   // Store $ra
      progTable[41] = encodeRType(5'd31, 5'd0, 5'd0, `MIPS_FN_JR);
   endtask

   // Expected stores from the MIPS rules
   task automatic buildExpected();
      expStores[0]  = '{addr: 32'h0000_0400, data: r1 + r2, pc: 32'h0000_001C};
      expStores[1]  = '{addr: 32'h0000_0404, data: r1 - r2, pc: 32'h0000_0024};
      expStores[2]  = '{addr: 32'h0000_0408, data: r1 & r2, pc: 32'h0000_002C};
      expStores[3]  = '{addr: 32'h0000_040C, data: r1 | r2, pc: 32'h0000_0034};
      expStores[4]  = '{addr: 32'h0000_0410,
                        data: ($signed(r1) < $signed(r2)) ? 32'd1 : 32'd0,
                        pc: 32'h0000_003C};
      expStores[5]  = '{addr: 32'h0000_0414,
                        data: ($signed(r2) < $signed(r1)) ? 32'd1 : 32'd0,
                        pc: 32'h0000_0044};
      expStores[6]  = '{addr: 32'h0000_0418, data: r1 | {16'h0000, c3},
                        pc: 32'h0000_004C};
      expStores[7]  = '{addr: 32'h0000_041C, data: r1 & {16'h0000, c4},
                        pc: 32'h0000_0054};
      expStores[8]  = '{addr: 32'h0000_0420, data: r1 + r2, pc: 32'h0000_005C};
      expStores[9]  = '{addr: 32'h0000_0424, data: 32'h0000_00A1, pc: 32'h0000_006C};
      expStores[10] = '{addr: 32'h0000_0428, data: 32'h0000_00B2, pc: 32'h0000_007C};
      expStores[11] = '{addr: 32'h0000_042C, data: 32'h0000_0080,  // jal at 0x7C plus 4
                        pc: 32'h0000_00A4};
      expStores[12] = '{addr: 32'h0000_0430, data: 32'h0000_0000, pc: 32'h0000_0090};
   endtask

   // Setup, then the memory write port and the first-fetch check
   initial
   begin
      rnd = $urandom(22321);
      rnd = $urandom();
      c1  = rnd[15:0];
      rnd = $urandom();
      c2  = rnd[15:0];
      rnd = $urandom();
      c3  = rnd[15:0];
      rnd = $urandom();
      c4  = rnd[15:0];
      if (c1 == 16'h0000)
         c1 = 16'h1234;      // Keeps the $zero write meaningful
      if (c2 == c1)
         c2 = c2 ^ 16'h0001; // beq/bne need $1 != $2
      r1 = {{16{c1[15]}}, c1};
      r2 = {{16{c2[15]}}, c2};

      buildProgram();
      buildExpected();
      for (int i = 0; i < MemWords; i++)
         mem[i] = ~(mipsPkg::word_t'(i) << 2);  // Inverted byte address
      for (int i = 0; i < ProgLen; i++)
         mem[i] = progTable[i];

      forever
      begin
         @(posedge iCLK);
         if (pendingWrite)
            mem[pendingAddr[10:2]] = pendingData;
         if (!firstReadChecked && !iRST)
         begin
            // Bus state of the first cycle out of reset
            checkValue("memReq.read", {31'd0, sampledRead}, 32'd1);
            checkValue("memReq.addr", sampledAddr, `MIPS_RESET_PC);
            firstReadChecked = 1'b1;
         end
      end
   end

   // Read port and bus sampling on the falling edge
   always @(negedge iCLK)
   begin
      if ((memReq.read === 1'b1 || memReq.write === 1'b1)
          && (memReq.addr >= MemWords * 4 || memReq.addr[1:0] != 2'b00))
         abortRun($sformatf("Memory access outside the model or unaligned at 0x%08h",
                            memReq.addr));
      memReadData  = (memReq.read === 1'b1) ? mem[memReq.addr[10:2]] : '0;
      sampledRead  = memReq.read;
      sampledAddr  = memReq.addr;
      pendingWrite = (memReq.write === 1'b1);
      pendingAddr  = memReq.addr;
      pendingData  = memReq.writeData;
      if (pendingWrite)
         checkStore(memReq.addr, memReq.writeData, pc);
   end

   // Watchdog
   initial
   begin
      #(TimeoutNs);
      abortRun($sformatf("Run timed out after %0d ns before the last expected store",
                         TimeoutNs));
   end

endmodule

// File: bench/mipsCore_asserts.sv
`timescale 1ns/10ps

module mipsCoreAsserts (
   input logic             iCLK,
   input logic             iRST,
   input mipsPkg::memReq_t memReq,
   input mipsPkg::word_t   pc
);

   // Strobes are mutually exclusive
   strobeExclusive: assert property (@(posedge iCLK) disable iff (iRST)
      !(memReq.read && memReq.write))
      else $error("memReq.read and memReq.write are high in the same cycle");

   // A store is a single-cycle pulse
   writeOneCycle: assert property (@(posedge iCLK) disable iff (iRST)
      memReq.write |=> !memReq.write)
      else $error("memReq.write stayed high for two cycles");

   pcAligned: assert property (@(posedge iCLK) disable iff (iRST)
      pc[1:0] == 2'b00)
      else $error("pc is not word aligned");  // Every target is a word address

   // No store while held in reset
   noWriteInReset: assert property (@(posedge iCLK)
      iRST |-> !memReq.write)
      else $error("memReq.write high during reset");

endmodule

bind mipsCore mipsCoreAsserts u_mipsCoreAsserts (
   .iCLK   (iCLK),
   .iRST   (iRST),
   .memReq (memReq),
   .pc     (pc)
);

// File: bench/tbClock.sv
`timescale 1ns/10ps

module tbClock #(
   parameter int Period      = 40,  // ns
   parameter int ResetCycles = 2
) (
   output logic iCLK,
   output logic iRST
);

   initial
   begin
      iCLK = 1'b0;
      forever #(Period / 2) iCLK = ~iCLK;
   end

   // Reset held over the first rising edges, released on a falling edge
   initial
   begin
      iRST = 1'b1;
      repeat (ResetCycles) @(posedge iCLK);
      @(negedge iCLK);
      iRST = 1'b0;
   end

endmodule

// File: src/mipsCore.sv
`timescale 1ns/10ps

module mipsCore (
   input  logic             iCLK,
   input  logic             iRST,
   output mipsPkg::memReq_t memReq,
   input  mipsPkg::word_t   memReadData,
   output mipsPkg::word_t   pc
);

   // Control to datapath
   mipsPkg::ctrlBus_t ctrl;

   // Decoded IR fields back to control
   mipsPkg::opcode_t  opcode;
   mipsPkg::funct_t   funct;

   mainControl u_mainControl (
      .iCLK   (iCLK),
      .iRST   (iRST),
      .opcode (opcode),
      .funct  (funct),
      .ctrl   (ctrl)
   );

   datapath u_datapath (
      .iCLK        (iCLK),
      .iRST        (iRST),
      .ctrl        (ctrl),
      .memReadData (memReadData),
      .memReq      (memReq),
      .opcode      (opcode),
      .funct       (funct),
      .pc          (pc)           // Current PC register
   );

endmodule

// File: src/datapath.sv
`timescale 1ns/10ps
`include "mips_defs.svh"

module datapath (
   input  logic              iCLK,
   input  logic              iRST,
   input  mipsPkg::ctrlBus_t ctrl,
   input  mipsPkg::word_t    memReadData,
   output mipsPkg::memReq_t  memReq,
   output mipsPkg::opcode_t  opcode,
   output mipsPkg::funct_t   funct,
   output mipsPkg::word_t    pc
);

   // Architectural and inter-state registers
   mipsPkg::word_t ir, a, b, mdr, aluOut;

   mipsPkg::regAddr_t rs, rt, rd, writeReg;
   mipsPkg::word_t    immS, immU, branchOff, jumpTarget;
   mipsPkg::word_t    readData1, readData2, regWriteData;
   mipsPkg::word_t    aluA, aluB, aluResult, pcNext;
   logic              aluZero, pcEn;

   // Instruction fields
   assign opcode     = ir[31:26];
   assign rs         = ir[25:21];
   assign rt         = ir[20:16];
   assign rd         = ir[15:11];
   assign funct      = ir[5:0];
   assign immS       = {{16{ir[15]}}, ir[15:0]};
   assign immU       = {16'b0, ir[15:0]};
   assign branchOff  = {{14{ir[15]}}, ir[15:0], 2'b00};  // Word offset
   assign jumpTarget = {pc[31:28], ir[25:0], 2'b00};     // Same 256 MB region

   // PC update, branch condition resolved here
   assign pcEn = ctrl.pcWrite
               | (ctrl.pcWriteBeq & aluZero)
               | (ctrl.pcWriteBne & ~aluZero);

   always_ff @(posedge iCLK)
   begin
      if (iRST)
      begin
         pc     <= `MIPS_RESET_PC;
         ir     <= '0;
         a      <= '0;
         b      <= '0;
         mdr    <= '0;
         aluOut <= '0;
      end
      else
      begin
         a      <= readData1;  // Refreshed every cycle, IR is stable
         b      <= readData2;
         aluOut <= aluResult;
         if (ctrl.memRead)
            mdr <= memReadData;
         if (ctrl.irWrite)
            ir <= memReadData;
         if (pcEn)
            pc <= pcNext;
      end
   end

   // Memory request
   assign memReq.addr      = ctrl.iorD ? aluOut : pc;
   assign memReq.writeData = b;
   assign memReq.read      = ctrl.memRead;
   assign memReq.write     = ctrl.memWrite;

   // Write register select
   always_comb
   begin
      case (ctrl.regDst)
         mipsPkg::dstRd:   writeReg = rd;
         mipsPkg::dstLink: writeReg = `MIPS_LINK_REG;
         default:          writeReg = rt;
      endcase
   end

   // Write data, PC for jal
   assign regWriteData = ctrl.writePc  ? pc
                       : ctrl.memToReg ? mdr
                       : aluOut;

   // ALU operands
   assign aluA = (ctrl.aluSrcA == mipsPkg::srcAReg) ? a : pc;

   always_comb
   begin
      case (ctrl.aluSrcB)
         mipsPkg::srcBFour:   aluB = mipsPkg::word_t'(4);
         mipsPkg::srcBImm:    aluB = immS;
         mipsPkg::srcBBranch: aluB = branchOff;
         mipsPkg::srcBUImm:   aluB = immU;
         default:             aluB = b;
      endcase
   end

   // Next PC select
   always_comb
   begin
      case (ctrl.pcSource)
         mipsPkg::pcAluOut: pcNext = aluOut;      // Branch target
         mipsPkg::pcJump:   pcNext = jumpTarget;
         mipsPkg::pcReg:    pcNext = a;           // jr
         default:           pcNext = aluResult;   // PC + 4
      endcase
   end

   registerFile u_registerFile (
      .iCLK      (iCLK),
      .iRST      (iRST),
      .readAddr1 (rs),
      .readAddr2 (rt),
      .writeAddr (writeReg),
      .writeData (regWriteData),
      .writeEn   (ctrl.regWrite),
      .readData1 (readData1),
      .readData2 (readData2)
   );

   aluUnit u_aluUnit (
      .opA    (aluA),
      .opB    (aluB),
      .aluOp  (ctrl.aluOp),
      .funct  (funct),
      .result (aluResult),
      .zero   (aluZero)
   );

endmodule

// File: src/mainControl.sv
`timescale 1ns/10ps
`include "mips_defs.svh"

module mainControl (
   input  logic              iCLK,
   input  logic              iRST,
   input  mipsPkg::opcode_t  opcode,
   input  mipsPkg::funct_t   funct,
   output mipsPkg::ctrlBus_t ctrl
);

   mipsPkg::ctrlState_e state, stateNext;

   // State register
   always_ff @(posedge iCLK)
   begin
      if (iRST)
         state <= mipsPkg::stFetch;
      else
         state <= stateNext;
   end

   // Sequencing by opcode
   always_comb
   begin
      stateNext = mipsPkg::stFetch;  // Most states finish the instruction
      case (state)
         mipsPkg::stFetch:      stateNext = mipsPkg::stDecode;
         mipsPkg::stDecode:
         begin
            case (opcode)
               `MIPS_OP_RTYPE:
                  // jr is an R-type distinguished by funct
                  stateNext = (funct == `MIPS_FN_JR) ? mipsPkg::stJumpReg
                                                     : mipsPkg::stRExecute;
               `MIPS_OP_ADDI,
               `MIPS_OP_ANDI,
               `MIPS_OP_ORI:    stateNext = mipsPkg::stImmExecute;
               `MIPS_OP_LW,
               `MIPS_OP_SW:     stateNext = mipsPkg::stMemAddr;
               `MIPS_OP_BEQ,
               `MIPS_OP_BNE:    stateNext = mipsPkg::stBranch;
               `MIPS_OP_J:      stateNext = mipsPkg::stJump;
               `MIPS_OP_JAL:    stateNext = mipsPkg::stJumpLink;
               default:         stateNext = mipsPkg::stFetch;  // Unknown, skip it
            endcase
         end
         mipsPkg::stMemAddr:
            stateNext = (opcode == `MIPS_OP_LW) ? mipsPkg::stMemLoad : mipsPkg::stMemStore;
         mipsPkg::stMemLoad:    stateNext = mipsPkg::stLoadWriteback;
         mipsPkg::stRExecute:   stateNext = mipsPkg::stRWriteback;
         mipsPkg::stImmExecute: stateNext = mipsPkg::stImmWriteback;
         default:               stateNext = mipsPkg::stFetch;
      endcase
   end

   // Control word per state, all fields idle unless set
   always_comb
   begin
      ctrl = '0;
      case (state)
         mipsPkg::stFetch:
         begin
            ctrl.memRead  = 1'b1;             // Read at PC
            ctrl.irWrite  = 1'b1;
            ctrl.aluSrcA  = mipsPkg::srcAPc;
            ctrl.aluSrcB  = mipsPkg::srcBFour;
            ctrl.aluOp    = mipsPkg::aluOpAdd;
            ctrl.pcSource = mipsPkg::pcAlu;   // PC + 4
            ctrl.pcWrite  = 1'b1;
         end
         mipsPkg::stDecode:
         begin
            // Branch target precomputed into ALUOut
            ctrl.aluSrcA = mipsPkg::srcAPc;
            ctrl.aluSrcB = mipsPkg::srcBBranch;
            ctrl.aluOp   = mipsPkg::aluOpAdd;
         end
         mipsPkg::stMemAddr:
         begin
            ctrl.aluSrcA = mipsPkg::srcAReg;  // base + offset
            ctrl.aluSrcB = mipsPkg::srcBImm;
            ctrl.aluOp   = mipsPkg::aluOpAdd;
         end
         mipsPkg::stMemLoad:
         begin
            ctrl.memRead = 1'b1;
            ctrl.iorD    = 1'b1;
         end
         mipsPkg::stLoadWriteback:
         begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = mipsPkg::dstRt;
            ctrl.memToReg = 1'b1;
         end
         mipsPkg::stMemStore:
         begin
            ctrl.memWrite = 1'b1;             // One cycle only
            ctrl.iorD     = 1'b1;
         end
         mipsPkg::stRExecute:
         begin
            ctrl.aluSrcA = mipsPkg::srcAReg;
            ctrl.aluSrcB = mipsPkg::srcBReg;
            ctrl.aluOp   = mipsPkg::aluOpFunct;
         end
         mipsPkg::stRWriteback:
         begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = mipsPkg::dstRd;
         end
         mipsPkg::stImmExecute:
         begin
            ctrl.aluSrcA = mipsPkg::srcAReg;
            // Logic immediates are zero-extended
            case (opcode)
               `MIPS_OP_ANDI:
               begin
                  ctrl.aluSrcB = mipsPkg::srcBUImm;
                  ctrl.aluOp   = mipsPkg::aluOpAnd;
               end
               `MIPS_OP_ORI:
               begin
                  ctrl.aluSrcB = mipsPkg::srcBUImm;
                  ctrl.aluOp   = mipsPkg::aluOpOr;
               end
               default:
               begin
                  ctrl.aluSrcB = mipsPkg::srcBImm;   // addi
                  ctrl.aluOp   = mipsPkg::aluOpAdd;
               end
            endcase
         end
         mipsPkg::stImmWriteback:
         begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = mipsPkg::dstRt;
         end
         mipsPkg::stBranch:
         begin
            ctrl.aluSrcA    = mipsPkg::srcAReg;  // Compare via A - B
            ctrl.aluSrcB    = mipsPkg::srcBReg;
            ctrl.aluOp      = mipsPkg::aluOpSub;
            ctrl.pcSource   = mipsPkg::pcAluOut;
            ctrl.pcWriteBeq = (opcode == `MIPS_OP_BEQ);
            ctrl.pcWriteBne = (opcode == `MIPS_OP_BNE);
         end
         mipsPkg::stJump:
         begin
            ctrl.pcSource = mipsPkg::pcJump;
            ctrl.pcWrite  = 1'b1;
         end
         mipsPkg::stJumpLink:
         begin
            ctrl.pcSource = mipsPkg::pcJump;
            ctrl.pcWrite  = 1'b1;
            ctrl.regWrite = 1'b1;             // $ra gets PC, already + 4
            ctrl.regDst   = mipsPkg::dstLink;
            ctrl.writePc  = 1'b1;
         end
         mipsPkg::stJumpReg:
         begin
            ctrl.pcSource = mipsPkg::pcReg;   // Target from rs
            ctrl.pcWrite  = 1'b1;
         end
         default: ctrl = '0;
      endcase
   end

endmodule

// File: src/aluUnit.sv
`timescale 1ns/10ps
`include "mips_defs.svh"

module aluUnit (
   input  mipsPkg::word_t   opA,
   input  mipsPkg::word_t   opB,
   input  mipsPkg::aluOp_e  aluOp,
   input  mipsPkg::funct_t  funct,
   output mipsPkg::word_t   result,
   output logic             zero
);

   mipsPkg::aluFunc_e aluFunc;

   // ALU control, maps request and funct to an operation
   always_comb
   begin
      case (aluOp)
         mipsPkg::aluOpSub: aluFunc = mipsPkg::aluSub;
         mipsPkg::aluOpAnd: aluFunc = mipsPkg::aluAnd;
         mipsPkg::aluOpOr:  aluFunc = mipsPkg::aluOr;
         mipsPkg::aluOpFunct:
         begin
            case (funct)
               `MIPS_FN_SUB: aluFunc = mipsPkg::aluSub;
               `MIPS_FN_AND: aluFunc = mipsPkg::aluAnd;
               `MIPS_FN_OR:  aluFunc = mipsPkg::aluOr;
               `MIPS_FN_SLT: aluFunc = mipsPkg::aluSlt;
               default:      aluFunc = mipsPkg::aluAdd;  // add and anything else
            endcase
         end
         default:           aluFunc = mipsPkg::aluAdd;
      endcase
   end

   // Arithmetic and logic
   always_comb
   begin
      case (aluFunc)
         mipsPkg::aluSub: result = opA - opB;
         mipsPkg::aluAnd: result = opA & opB;
         mipsPkg::aluOr:  result = opA | opB;
         mipsPkg::aluSlt:
            // Signed compare, result is 0 or 1
            result = ($signed(opA) < $signed(opB)) ? mipsPkg::word_t'(1) : '0;
         default:         result = opA + opB;
      endcase
   end

   assign zero = (result == '0);  // Used by beq/bne

endmodule

// File: src/registerFile.sv
`timescale 1ns/10ps
`include "mips_defs.svh"

module registerFile (
   input  logic              iCLK,
   input  logic              iRST,
   input  mipsPkg::regAddr_t readAddr1,
   input  mipsPkg::regAddr_t readAddr2,
   input  mipsPkg::regAddr_t writeAddr,
   input  mipsPkg::word_t    writeData,
   input  logic              writeEn,
   output mipsPkg::word_t    readData1,
   output mipsPkg::word_t    readData2
);

   localparam int NumRegs = 1 << `MIPS_REG_ADDR_W;

   mipsPkg::word_t regs [NumRegs];

   // Write port, $zero never changes
   always_ff @(posedge iCLK)
   begin
      if (iRST)
      begin
         for (int i = 0; i < NumRegs; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (writeEn && (writeAddr != '0))
      begin
         regs[writeAddr] <= writeData;
      end
   end

   // Asynchronous read ports
   assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
   assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

// File: src/mipsPkg.sv
`include "mips_defs.svh"

package mipsPkg;

   // Basic fields
   typedef logic [`MIPS_WORD_W-1:0]     word_t;    // Data or address word
   typedef logic [`MIPS_REG_ADDR_W-1:0] regAddr_t; // Register index
   typedef logic [5:0]                  opcode_t;  // IR[31:26]
   typedef logic [5:0]                  funct_t;   // IR[5:0]

   // Multicycle control states
   typedef enum logic [3:0] {
      stFetch,
      stDecode,
      stMemAddr,
      stMemLoad,
      stLoadWriteback,
      stMemStore,
      stRExecute,
      stRWriteback,
      stImmExecute,
      stImmWriteback,
      stBranch,
      stJump,
      stJumpLink,
      stJumpReg
   } ctrlState_e;

   // What control asks of the ALU
   typedef enum logic [2:0] {
      aluOpAdd,
      aluOpSub,
      aluOpFunct,  // Let funct decide (R-type)
      aluOpAnd,
      aluOpOr
   } aluOp_e;

   // Operation actually performed
   typedef enum logic [2:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluOr,
      aluSlt
   } aluFunc_e;

   typedef enum logic {srcAPc, srcAReg} aluSrcA_e;

   typedef enum logic [2:0] {
      srcBReg,     // B register
      srcBFour,    // Constant 4 for PC + 4
      srcBImm,     // Sign-extended immediate
      srcBBranch,  // Sign-extended immediate shifted by 2
      srcBUImm     // Zero-extended immediate
   } aluSrcB_e;

   typedef enum logic [1:0] {pcAlu, pcAluOut, pcJump, pcReg} pcSrc_e;

   typedef enum logic [1:0] {dstRt, dstRd, dstLink} regDst_e;

   // Everything control hands to the datapath
   typedef struct packed {
      logic     irWrite;
      logic     memRead;
      logic     memWrite;
      logic     iorD;        // Memory address from ALUOut instead of PC
      logic     pcWrite;
      logic     pcWriteBeq;
      logic     pcWriteBne;
      pcSrc_e   pcSource;
      aluSrcA_e aluSrcA;
      aluSrcB_e aluSrcB;
      aluOp_e   aluOp;
      logic     regWrite;
      regDst_e  regDst;
      logic     memToReg;
      logic     writePc;     // Register write data is PC (jal)
   } ctrlBus_t;

   // Strobe bus toward external memory
   typedef struct packed {
      word_t addr;
      word_t writeData;
      logic  read;
      logic  write;
   } memReq_t;

endpackage

// File: src/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Datapath widths
`define MIPS_WORD_W      32
`define MIPS_REG_ADDR_W  5

// First instruction fetched after reset
`define MIPS_RESET_PC    32'h0000_0000

// Return address register for jal ($ra)
`define MIPS_LINK_REG    5'd31

// Opcodes, bits 31:26 of the instruction
`define MIPS_OP_RTYPE    6'h00
`define MIPS_OP_J        6'h02
`define MIPS_OP_JAL      6'h03
`define MIPS_OP_BEQ      6'h04
`define MIPS_OP_BNE      6'h05
`define MIPS_OP_ADDI     6'h08
`define MIPS_OP_ANDI     6'h0C
`define MIPS_OP_ORI      6'h0D
`define MIPS_OP_LW       6'h23
`define MIPS_OP_SW       6'h2B

// Funct codes for R-type, bits 5:0
`define MIPS_FN_JR       6'h08
`define MIPS_FN_ADD      6'h20
`define MIPS_FN_SUB      6'h22
`define MIPS_FN_AND      6'h24
`define MIPS_FN_OR       6'h25
`define MIPS_FN_SLT      6'h2A

`endif
